// File: bpu_params.svh
`ifndef BPU_PARAMS_SVH
`define BPU_PARAMS_SVH

// Address and fetch block geometry.
`define XLEN 32
`define INSTR_PER_FETCH 4
`define SLOT_W 2

// BTB is indexed by PC[6:2], so one block covers four distinct entries.
`define BTB_ENTRIES 32
`define BTB_IDX_W 5
`define BLK_W 3
`define TAG_W 25

`define BHT_ENTRIES 64
`define BHT_IDX_W 6
`define BHT_BLK_W 4

`define RAS_DEPTH 8
`define RAS_PTR_W 3

`endif

// File: bpu_pkg.sv
`default_nettype none

`include "bpu_params.svh"

package bpu_pkg;

  typedef enum logic [1:0] {
    br_cond = 2'd0,
    br_jump = 2'd1,
    br_call = 2'd2,
    br_ret  = 2'd3
  } branch_kind_e;

  // Fetch PC split into table fields.
  typedef struct packed {
    logic [`TAG_W-1:0]  tag;
    logic [`BLK_W-1:0]  blk;
    logic [`SLOT_W-1:0] slot;
    logic [1:0]         byte_off;
  } fetch_fields_t;

  typedef union packed {
    logic [`XLEN-1:0] raw;
    fetch_fields_t    f;
  } fetch_addr_u;

  typedef struct packed {
    logic              valid;
    logic [`TAG_W-1:0] tag;
    branch_kind_e      kind;
    logic [`XLEN-1:0]  target;
  } btb_entry_t;

endpackage

`default_nettype wire

// File: bpu_update_if.sv
`default_nettype none

`include "bpu_params.svh"

// Commit-time training bundle, one strobe per update.
interface bpu_update_if;

  logic             update_valid;
  logic [`XLEN-1:0] pc;
  logic             is_cond;
  logic             taken;
  logic [`XLEN-1:0] target;
  logic             is_call;
  logic             is_ret;

  modport tables (
    input update_valid,
    input pc,
    input is_cond,
    input taken,
    input target,
    input is_call,
    input is_ret
  );

endinterface

`default_nettype wire

// File: bpu_lookup_if.sv
`default_nettype none

`include "bpu_params.svh"

interface bpu_lookup_if;
  import bpu_pkg::*;

  logic                                         req_valid;
  fetch_addr_u                                  req_addr;
  logic [`INSTR_PER_FETCH-1:0]                  slot_mask;

  // Per-slot table results.
  logic [`INSTR_PER_FETCH-1:0]                  btb_hit;
  branch_kind_e [`INSTR_PER_FETCH-1:0]          btb_kind;
  logic [`INSTR_PER_FETCH-1:0][`XLEN-1:0]       btb_target;
  logic [`INSTR_PER_FETCH-1:0]                  bht_taken;
  logic [`XLEN-1:0]                             ras_top;

  modport fetch (output req_valid, output req_addr, output slot_mask);

  modport btb (input req_addr, output btb_hit, output btb_kind, output btb_target);

  modport bht (input req_addr, output bht_taken);

  modport ras (output ras_top);

  modport select (
    input req_valid, input req_addr, input slot_mask,
    input btb_hit, input btb_kind, input btb_target,
    input bht_taken, input ras_top
  );

endinterface

`default_nettype wire

// File: bpu_fetch_stage.sv
`default_nettype none

`include "bpu_params.svh"

module bpu_fetch_stage (
  input  wire logic             clk_i,
  input  wire logic             arst_n_i,
  input  wire logic             ifu_valid_i,
  input  wire logic             ifu_ready_i,
  input  wire logic [`XLEN-1:0] pc_i,
  input  wire logic             flush_i,
  bpu_lookup_if.fetch           lookup
);
  import bpu_pkg::*;

  logic        accept;
  logic        req_valid_q;
  fetch_addr_u req_q;

  assign accept = ifu_valid_i && ifu_ready_i;

  // A request taken together with a flush is dropped.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= accept && !flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q.raw <= pc_i;
    end
  end

  // Slots ahead of the entry slot are not executed.
  always_comb begin
    for (int s = 0; s < `INSTR_PER_FETCH; s++) begin
      lookup.slot_mask[s] = (s >= int'(req_q.f.slot));
    end
  end

  assign lookup.req_valid = req_valid_q;
  assign lookup.req_addr  = req_q;

endmodule

`default_nettype wire

// File: bpu_btb.sv
`default_nettype none

`include "bpu_params.svh"

module bpu_btb (
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  bpu_update_if.tables  upd,
  bpu_lookup_if.btb     lookup
);
  import bpu_pkg::*;

  btb_entry_t             mem_q [`BTB_ENTRIES];
  fetch_addr_u            upd_addr;
  logic [`BTB_IDX_W-1:0]  wr_idx;
  logic                   wr_en;
  btb_entry_t             wr_entry;

  assign upd_addr.raw = upd.pc;
  assign wr_idx       = {upd_addr.f.blk, upd_addr.f.slot};

  // Not-taken conditionals keep whatever entry is there.
  assign wr_en = upd.update_valid && (upd.taken || upd.is_call || upd.is_ret);

  always_comb begin
    wr_entry.valid  = 1'b1;
    wr_entry.tag    = upd_addr.f.tag;
    wr_entry.target = upd.target;
    if (upd.is_ret) begin
      wr_entry.kind = br_ret;
    end else if (upd.is_call) begin
      wr_entry.kind = br_call;
    end else if (upd.is_cond) begin
      wr_entry.kind = br_cond;
    end else begin
      wr_entry.kind = br_jump;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `BTB_ENTRIES; i++) begin
        mem_q[i].valid <= 1'b0;
      end
    end else if (wr_en) begin
      mem_q[wr_idx] <= wr_entry;
    end
  end

  // One read port per slot of the block.
  for (genvar s = 0; s < `INSTR_PER_FETCH; s++) begin : g_slot
    logic [`BTB_IDX_W-1:0] rd_idx;
    btb_entry_t            rd_entry;

    assign rd_idx   = {lookup.req_addr.f.blk, `SLOT_W'(s)};
    assign rd_entry = mem_q[rd_idx];

    assign lookup.btb_hit[s]    = rd_entry.valid && (rd_entry.tag == lookup.req_addr.f.tag);
    assign lookup.btb_kind[s]   = rd_entry.kind;
    assign lookup.btb_target[s] = rd_entry.target;
  end

endmodule

`default_nettype wire

// File: bpu_bht.sv
`default_nettype none

`include "bpu_params.svh"

module bpu_bht (
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  bpu_update_if.tables  upd,
  bpu_lookup_if.bht     lookup
);
  import bpu_pkg::*;

  logic [1:0]            cnt_q [`BHT_ENTRIES];
  fetch_addr_u           upd_addr;
  logic [`BHT_IDX_W-1:0] wr_idx;
  logic [1:0]            cnt_cur;
  logic [1:0]            cnt_nxt;

  assign upd_addr.raw = upd.pc;
  assign wr_idx  = {upd_addr.f.tag[0], upd_addr.f.blk, upd_addr.f.slot};
  assign cnt_cur = cnt_q[wr_idx];

  // Saturating 2-bit counter.
  always_comb begin
    if (upd.taken) begin
      cnt_nxt = (cnt_cur == 2'd3) ? cnt_cur : cnt_cur + 2'd1;
    end else begin
      cnt_nxt = (cnt_cur == 2'd0) ? cnt_cur : cnt_cur - 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `BHT_ENTRIES; i++) begin
        cnt_q[i] <= 2'd1;
      end
    end else if (upd.update_valid && upd.is_cond) begin
      cnt_q[wr_idx] <= cnt_nxt;
    end
  end

  for (genvar s = 0; s < `INSTR_PER_FETCH; s++) begin : g_slot
    logic [`BHT_IDX_W-1:0] rd_idx;

    assign rd_idx = {lookup.req_addr.f.tag[0], lookup.req_addr.f.blk, `SLOT_W'(s)};
    assign lookup.bht_taken[s] = cnt_q[rd_idx][1];
  end

endmodule

`default_nettype wire

// File: bpu_ras.sv
`default_nettype none

`include "bpu_params.svh"

module bpu_ras (
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  bpu_update_if.tables  upd,
  bpu_lookup_if.ras     lookup
);

  logic [`XLEN-1:0]      stack_q [`RAS_DEPTH];
  logic [`RAS_PTR_W-1:0] ptr_q;
  logic [`RAS_PTR_W-1:0] pop_ptr;
  logic [`RAS_PTR_W-1:0] top_ptr;

  // Pop first, so a call-return pair replaces the top.
  assign pop_ptr = upd.is_ret ? ptr_q - `RAS_PTR_W'd1 : ptr_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
      for (int i = 0; i < `RAS_DEPTH; i++) begin
        stack_q[i] <= '0;
      end
    end else if (upd.update_valid) begin
      if (upd.is_call) begin
        stack_q[pop_ptr] <= upd.pc + `XLEN'd4;
        ptr_q            <= pop_ptr + `RAS_PTR_W'd1;
      end else begin
        ptr_q <= pop_ptr;
      end
    end
  end

  // Pointer wraps, so old entries get overwritten.
  assign top_ptr        = ptr_q - `RAS_PTR_W'd1;
  assign lookup.ras_top = stack_q[top_ptr];

endmodule

`default_nettype wire

// File: bpu_npc_select.sv
`default_nettype none

`include "bpu_params.svh"

module bpu_npc_select (
  bpu_lookup_if.select             lookup,
  output logic                     bpu_valid_o,
  output logic [`XLEN-1:0]         npc_o,
  output logic                     pred_slot_valid_o,
  output logic [`SLOT_W-1:0]       pred_slot_idx_o,
  output logic [`XLEN-1:0]         pred_slot_target_o
);
  import bpu_pkg::*;

  logic [`INSTR_PER_FETCH-1:0] taken;
  logic [`SLOT_W-1:0]          win_idx;
  logic [`XLEN-1:0]            win_target;
  logic [`XLEN-1:0]            fall_through;

  always_comb begin
    for (int s = 0; s < `INSTR_PER_FETCH; s++) begin
      taken[s] = lookup.slot_mask[s] && lookup.btb_hit[s] &&
                 (lookup.btb_kind[s] != br_cond || lookup.bht_taken[s]);
    end
  end

  // Scan downwards, lowest taken slot wins.
  always_comb begin
    win_idx = '0;
    for (int s = `INSTR_PER_FETCH - 1; s >= 0; s--) begin
      if (taken[s]) begin
        win_idx = `SLOT_W'(s);
      end
    end
  end

  assign win_target = (lookup.btb_kind[win_idx] == br_ret) ? lookup.ras_top :
                      lookup.btb_target[win_idx];

  assign fall_through = {lookup.req_addr.f.tag, lookup.req_addr.f.blk, `SLOT_W'(0), 2'b00} +
                        `XLEN'(4 * `INSTR_PER_FETCH);

  always_comb begin
    bpu_valid_o        = lookup.req_valid;
    pred_slot_valid_o  = lookup.req_valid && (|taken);
    pred_slot_idx_o    = pred_slot_valid_o ? win_idx : '0;
    pred_slot_target_o = pred_slot_valid_o ? win_target : '0;
    if (!lookup.req_valid) begin
      npc_o = '0;
    end else begin
      npc_o = (|taken) ? win_target : fall_through;
    end
  end

endmodule

`default_nettype wire

// File: bpu.sv
`default_nettype none

`include "bpu_params.svh"

module bpu (
  input  wire logic             clk_i,
  input  wire logic             arst_n_i,
  input  wire logic             ifu_valid_i,
  input  wire logic             ifu_ready_i,
  input  wire logic [`XLEN-1:0] pc_i,
  input  wire logic             flush_i,
  input  wire logic             update_valid_i,
  input  wire logic [`XLEN-1:0] update_pc_i,
  input  wire logic             update_is_cond_i,
  input  wire logic             update_taken_i,
  input  wire logic [`XLEN-1:0] update_target_i,
  input  wire logic             update_is_call_i,
  input  wire logic             update_is_ret_i,
  output logic                  bpu_valid_o,
  output logic [`XLEN-1:0]      npc_o,
  output logic                  pred_slot_valid_o,
  output logic [`SLOT_W-1:0]    pred_slot_idx_o,
  output logic [`XLEN-1:0]      pred_slot_target_o
);

  bpu_update_if upd ();
  bpu_lookup_if lookup ();

  // Commit port feeds all three tables.
  assign upd.update_valid = update_valid_i;
  assign upd.pc           = update_pc_i;
  assign upd.is_cond      = update_is_cond_i;
  assign upd.taken        = update_taken_i;
  assign upd.target       = update_target_i;
  assign upd.is_call      = update_is_call_i;
  assign upd.is_ret       = update_is_ret_i;

  bpu_fetch_stage u_fetch (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .ifu_valid_i (ifu_valid_i),
    .ifu_ready_i (ifu_ready_i),
    .pc_i        (pc_i),
    .flush_i     (flush_i),
    .lookup      (lookup.fetch)
  );

  bpu_btb u_btb (.clk_i(clk_i), .arst_n_i(arst_n_i), .upd(upd.tables), .lookup(lookup.btb));

  bpu_bht u_bht (.clk_i(clk_i), .arst_n_i(arst_n_i), .upd(upd.tables), .lookup(lookup.bht));

  bpu_ras u_ras (.clk_i(clk_i), .arst_n_i(arst_n_i), .upd(upd.tables), .lookup(lookup.ras));

  bpu_npc_select u_select (
    .lookup             (lookup.select),
    .bpu_valid_o        (bpu_valid_o),
    .npc_o              (npc_o),
    .pred_slot_valid_o  (pred_slot_valid_o),
    .pred_slot_idx_o    (pred_slot_idx_o),
    .pred_slot_target_o (pred_slot_target_o)
  );

endmodule

`default_nettype wire

// File: tb_bpu_model.svh
`ifndef TB_BPU_MODEL_SVH
`define TB_BPU_MODEL_SVH

// Reference copies of the BTB, BHT and RAS.
logic         m_btb_valid  [`BTB_ENTRIES];
logic [24:0]  m_btb_tag    [`BTB_ENTRIES];
branch_kind_e m_btb_kind   [`BTB_ENTRIES];
logic [31:0]  m_btb_target [`BTB_ENTRIES];
logic [1:0]   m_bht        [`BHT_ENTRIES];
logic [31:0]  m_ras        [`RAS_DEPTH];
logic [2:0]   m_ras_ptr;

task automatic reset_tables();
  for (int i = 0; i < `BTB_ENTRIES; i++) m_btb_valid[i] = 1'b0;
  for (int i = 0; i < `BHT_ENTRIES; i++) m_bht[i] = 2'd1;
  for (int i = 0; i < `RAS_DEPTH; i++) m_ras[i] = 32'd0;
  m_ras_ptr = 3'd0;
endtask

task automatic train_tables(input logic [31:0] pc, input logic is_cond, input logic taken,
                            input logic [31:0] target, input logic is_call,
                            input logic is_ret);
  logic [2:0] p;
  if (taken || is_call || is_ret) begin
    m_btb_valid[pc[6:2]]  = 1'b1;
    m_btb_tag[pc[6:2]]    = pc[31:7];
    m_btb_target[pc[6:2]] = target;
    m_btb_kind[pc[6:2]]   = is_ret ? br_ret : is_call ? br_call : is_cond ? br_cond : br_jump;
  end
  if (is_cond && taken && m_bht[pc[7:2]] != 2'd3) m_bht[pc[7:2]] = m_bht[pc[7:2]] + 2'd1;
  if (is_cond && !taken && m_bht[pc[7:2]] != 2'd0) m_bht[pc[7:2]] = m_bht[pc[7:2]] - 2'd1;
  // Pop comes before push.
  p = m_ras_ptr;
  if (is_ret) p = p - 3'd1;
  if (is_call) begin
    m_ras[p] = pc + 32'd4;
    p = p + 3'd1;
  end
  m_ras_ptr = p;
endtask

task automatic predict_block(input logic [31:0] pc);
  logic [31:0] base;
  logic [31:0] a;
  logic        hit;
  base           = {pc[31:4], 4'b0000};
  exp_slot_valid = 1'b0;
  exp_idx        = 2'd0;
  exp_target     = 32'd0;
  for (int s = 0; s < `INSTR_PER_FETCH; s++) begin
    a   = base + 32'(4 * s);
    hit = m_btb_valid[a[6:2]] && (m_btb_tag[a[6:2]] == a[31:7]);
    if (!exp_slot_valid && s >= int'(pc[3:2]) && hit &&
        (m_btb_kind[a[6:2]] != br_cond || m_bht[a[7:2]] >= 2'd2)) begin
      exp_slot_valid = 1'b1;
      exp_idx        = 2'(s);
      exp_target     = (m_btb_kind[a[6:2]] == br_ret) ? m_ras[m_ras_ptr - 3'd1] :
                       m_btb_target[a[6:2]];
    end
  end
  exp_npc = exp_slot_valid ? exp_target : base + 32'd16;
endtask

`endif

// File: tb_bpu.sv
`default_nettype none

`include "bpu_params.svh"

module tb_bpu;
  import bpu_pkg::*;

  localparam int          NUM_OPS        = 2000;
  localparam int          TIMEOUT_CYCLES = NUM_OPS + NUM_OPS / 4;
  localparam logic [31:0] SEED           = 32'h9215_7f42;

  logic        clk_i, arst_n_i, ifu_valid_i, ifu_ready_i, flush_i;
  logic [31:0] pc_i;
  logic        update_valid_i, update_is_cond_i, update_taken_i;
  logic        update_is_call_i, update_is_ret_i;
  logic [31:0] update_pc_i, update_target_i;
  logic        bpu_valid_o, pred_slot_valid_o;
  logic [31:0] npc_o, pred_slot_target_o;
  logic [1:0]  pred_slot_idx_o;

  logic [31:0] pool [16];
  logic        exp_valid, exp_slot_valid;
  logic [1:0]  exp_idx;
  logic [31:0] exp_target, exp_npc;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  `include "tb_bpu_model.svh"

  bpu u_bpu (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error: %s got %h, expected %h", name, got, exp);
    end
  endtask

  // Op 0 is a clean lookup with no update.
  task automatic drive_stimulus(input int op);
    logic [31:0] r;
    logic [31:0] t;
    r = $urandom();
    t = $urandom();
    ifu_valid_i      <= (r[1:0] != 2'b00) || (op == 0);
    ifu_ready_i      <= (r[3:2] != 2'b00) || (op == 0);
    flush_i          <= (r[7:4] == 4'h0) && (op != 0);
    pc_i             <= pool[r[11:8]] | {28'd0, r[13:12], 2'b00};
    update_valid_i   <= r[14] && (op != 0);
    update_pc_i      <= pool[r[18:15]] | {28'd0, r[20:19], 2'b00};
    update_target_i  <= {t[31:2], 2'b00};
    update_is_cond_i <= (r[22:21] == 2'd0);
    update_taken_i   <= (r[22:21] != 2'd0) || r[23];
    update_is_call_i <= (r[22:21] == 2'd2) || (r[26:24] == 3'd0);
    update_is_ret_i  <= (r[22:21] == 2'd3);
  endtask

  initial begin
    void'($urandom(SEED));
    arst_n_i         = 1'b0;
    ifu_valid_i      = 1'b0;
    ifu_ready_i      = 1'b0;
    flush_i          = 1'b0;
    pc_i             = 32'd0;
    update_valid_i   = 1'b0;
    update_pc_i      = 32'd0;
    update_is_cond_i = 1'b0;
    update_taken_i   = 1'b0;
    update_target_i  = 32'd0;
    update_is_call_i = 1'b0;
    update_is_ret_i  = 1'b0;
    // Small block pool so tables hit and sets collide.
    for (int i = 0; i < 16; i++) pool[i] = $urandom() & 32'h0000_3ff0;
    reset_tables();
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_value("bpu_valid_o", 32'(bpu_valid_o), 32'd0);
    check_value("pred_slot_valid_o", 32'(pred_slot_valid_o), 32'd0);

    for (int op = 0; op < NUM_OPS; op++) begin
      @(posedge clk_i);
      // Update first, then the request sampled at the same edge.
      if (update_valid_i) begin
        train_tables(update_pc_i, update_is_cond_i, update_taken_i, update_target_i,
                     update_is_call_i, update_is_ret_i);
      end
      exp_valid = ifu_valid_i && ifu_ready_i && !flush_i;
      if (exp_valid) begin
        predict_block(pc_i);
      end else begin
        exp_slot_valid = 1'b0;
        exp_idx        = 2'd0;
        exp_target     = 32'd0;
        exp_npc        = 32'd0;
      end
      drive_stimulus(op);
      @(negedge clk_i);
      check_value("bpu_valid_o", 32'(bpu_valid_o), 32'(exp_valid));
      check_value("npc_o", npc_o, exp_npc);
      check_value("pred_slot_valid_o", 32'(pred_slot_valid_o), 32'(exp_slot_valid));
      check_value("pred_slot_idx_o", 32'(pred_slot_idx_o), 32'(exp_idx));
      check_value("pred_slot_target_o", pred_slot_target_o, exp_target);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
bpu_pkg.sv
bpu_update_if.sv
bpu_lookup_if.sv
bpu_fetch_stage.sv
bpu_btb.sv
bpu_bht.sv
bpu_ras.sv
bpu_npc_select.sv
bpu.sv
tb_bpu.sv

// File: run.sh
#!/bin/sh
# Builds and runs the BPU testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_bpu -o tb_bpu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_bpu_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
